//--- logic/core_pkg.sv
package core_pkg;

    localparam int addr_w = 16;
    localparam int data_w = 8;

    // opcode bytes as seen in program memory
    typedef enum logic [7:0]
    {
        op_nop      = 8'hFF,
        op_ld_a_imm = 8'hB0,
        op_ld_b_imm = 8'hB1,
        op_add_imm  = 8'h02,
        op_sub_imm  = 8'h12,
        op_and_imm  = 8'h22,
        op_or_imm   = 8'h2A,
        op_xor_imm  = 8'h32,
        op_inc_a    = 8'h80,
        op_dec_a    = 8'h88,
        op_jrs      = 8'hF1,
        op_jrl      = 8'hF3,
        op_st_a     = 8'hB4,
        op_st_b     = 8'hB5
    } opcode_e;

    // taken from the low three bits of the condition byte of a jump
    typedef enum logic [2:0]
    {
        cond_always    = 3'd0,
        cond_carry     = 3'd1,
        cond_non_carry = 3'd2,
        cond_zero      = 3'd3,
        cond_non_zero  = 3'd4,
        cond_minus     = 3'd5,
        cond_plus      = 3'd6
    } cond_e;

    typedef enum logic [2:0]
    {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_inc,
        alu_dec
    } alu_op_e;

    typedef struct packed
    {
        logic z;
        logic c;
        logic v;
        logic n;
    } flags_t;

    typedef struct packed
    {
        opcode_e           opcode;
        cond_e             cond;
        logic [15:0]       imm;
        logic [addr_w-1:0] next_pc;
    } insn_t;

    typedef struct packed
    {
        logic              valid;
        logic [addr_w-1:0] target;
    } redirect_t;

    typedef struct packed
    {
        logic              valid;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
    } store_t;

    // jumps carry a condition byte ahead of their offset
    function automatic logic [2:0] insn_length(input logic [data_w-1:0] opcode_byte);
        logic [2:0] len;
        case (opcode_byte)
            op_ld_a_imm, op_ld_b_imm, op_add_imm, op_sub_imm,
            op_and_imm, op_or_imm, op_xor_imm:
                len = 3'd2;
            op_jrs, op_st_a, op_st_b:
                len = 3'd3;
            op_jrl:
                len = 3'd4;
            default:
                len = 3'd1;
        endcase
        return len;
    endfunction

endpackage

//--- logic/alu.sv
`timescale 1ns/1ns

module alu
(
    input  core_pkg::alu_op_e              op,
    input  logic [core_pkg::data_w-1:0]    a,
    input  logic [core_pkg::data_w-1:0]    b,
    input  logic                           carry_in,
    output logic [core_pkg::data_w-1:0]    result,
    output core_pkg::flags_t               flags
);
    import core_pkg::*;

    logic [data_w:0] wide;

    always_comb
    begin
        wide    = '0;
        result  = '0;
        flags.c = carry_in;
        flags.v = 1'b0;
        case (op)
            alu_add:
            begin
                wide    = {1'b0, a} + {1'b0, b};
                result  = wide[data_w-1:0];
                flags.c = wide[data_w];
                flags.v = (a[7] == b[7]) && (result[7] != a[7]);
            end
            alu_sub:
            begin
                // the ninth bit is the borrow
                wide    = {1'b0, a} - {1'b0, b};
                result  = wide[data_w-1:0];
                flags.c = wide[data_w];
                flags.v = (a[7] != b[7]) && (result[7] != a[7]);
            end
            alu_and:
                result = a & b;
            alu_or:
                result = a | b;
            alu_xor:
                result = a ^ b;
            alu_inc:
            begin
                result  = a + 1'b1;
                flags.v = (a == 8'h7F);
            end
            default:
            begin
                result  = a - 1'b1;
                flags.v = (a == 8'h80);
            end
        endcase
        flags.z = (result == '0);
        flags.n = result[7];
    end

endmodule

//--- logic/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit
(
    input  logic                          clk,
    input  logic                          reset,
    output logic                          imem_req,
    output logic [core_pkg::addr_w-1:0]   imem_addr,
    input  logic [core_pkg::data_w-1:0]   imem_data,
    input  core_pkg::redirect_t           redirect,
    output core_pkg::insn_t               fetch_insn,
    output logic                          fetch_valid,
    input  logic                          fetch_ready
);
    import core_pkg::*;

    typedef enum logic [1:0]
    {
        st_first,
        st_operand,
        st_full
    } state_e;

    state_e state;
    logic [addr_w-1:0] pc;
    logic [addr_w-1:0] pend_addr;
    logic pend;
    logic pend_tag;
    logic epoch;
    logic fetch_en;
    logic [2:0] got;
    logic [2:0] len;
    logic [2:0] new_len;
    logic byte_in;
    logic last_byte;
    logic is_jump;
    logic [2:0] imm_lo_idx;
    insn_t rec;

    // a byte only counts if its request was made in the current epoch
    assign byte_in = pend && (pend_tag == epoch);
    assign new_len = insn_length(imem_data);
    assign last_byte = byte_in &&
        ((state == st_first && new_len == 3'd1) ||
         (state == st_operand && 3'(got + 3'd1) == len));

    // no request while the final byte of a record is on its way in
    assign imem_req = fetch_en && ((state == st_full) ? fetch_ready : !last_byte);
    assign imem_addr = pc;

    assign is_jump = (rec.opcode == op_jrs) || (rec.opcode == op_jrl);
    assign imm_lo_idx = is_jump ? 3'd2 : 3'd1;

    assign fetch_valid = (state == st_full);
    assign fetch_insn = rec;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state    <= st_first;
            pc       <= '0;
            pend     <= 1'b0;
            pend_tag <= 1'b0;
            epoch    <= 1'b0;
            fetch_en <= 1'b0;
            got      <= '0;
            len      <= '0;
        end
        else
        begin
            fetch_en <= 1'b1;
            pend     <= imem_req;
            pend_tag <= epoch;
            if (imem_req)
                pc <= pc + 1'b1;

            if (redirect.valid)
            begin
                pc    <= redirect.target;
                epoch <= ~epoch;
                state <= st_first;
                got   <= '0;
            end
            else
            begin
                case (state)
                    st_first:
                        if (byte_in)
                        begin
                            len   <= new_len;
                            got   <= 3'd1;
                            state <= (new_len == 3'd1) ? st_full : st_operand;
                        end
                    st_operand:
                        if (byte_in)
                        begin
                            got <= got + 3'd1;
                            if (3'(got + 3'd1) == len)
                                state <= st_full;
                        end
                    default:
                        if (fetch_ready)
                            state <= st_first;
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (imem_req)
            pend_addr <= pc;

        if (byte_in)
        begin
            rec.next_pc <= pend_addr + 1'b1;
            if (state == st_first)
            begin
                rec.opcode <= opcode_e'(imem_data);
                rec.cond   <= cond_always;
                rec.imm    <= '0;
            end
            else if (is_jump && got == 3'd1)
                rec.cond <= cond_e'(imem_data[2:0]);
            else if (got == imm_lo_idx)
                rec.imm[7:0] <= imem_data;
            else
                rec.imm[15:8] <= imem_data;
        end
    end

endmodule

//--- logic/insn_queue.sv
`timescale 1ns/1ns

module insn_queue
#(
    parameter int queue_depth = 4
)
(
    input  logic                 clk,
    input  logic                 reset,
    input  core_pkg::insn_t      fetch_insn,
    input  logic                 fetch_valid,
    output logic                 fetch_ready,
    output core_pkg::insn_t      exec_insn,
    output logic                 exec_valid,
    input  logic                 exec_ready,
    input  core_pkg::redirect_t  redirect
);
    import core_pkg::*;

    localparam int ptr_w = $clog2(queue_depth);

    insn_t mem [queue_depth];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w:0] count;
    logic wr_en;
    logic rd_en;

    assign fetch_ready = (count != (ptr_w + 1)'(queue_depth));
    assign exec_valid = (count != '0);
    assign exec_insn = mem[rd_ptr];

    assign wr_en = fetch_valid && fetch_ready;
    assign rd_en = exec_valid && exec_ready;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end
        else if (redirect.valid)
        begin
            // everything queued behind a taken jump is on the wrong path
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + (ptr_w + 1)'(wr_en) - (ptr_w + 1)'(rd_en);
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_ptr] <= fetch_insn;
    end

endmodule

//--- logic/execute_unit.sv
`timescale 1ns/1ns

module execute_unit
(
    input  logic                 clk,
    input  logic                 reset,
    input  core_pkg::insn_t      exec_insn,
    input  logic                 exec_valid,
    output logic                 exec_ready,
    output core_pkg::redirect_t  redirect,
    output core_pkg::store_t     mem_store
);
    import core_pkg::*;

    // SC bit positions as on the S1C88, interrupt mask bits sit above N
    localparam int sc_z = 0;
    localparam int sc_c = 1;
    localparam int sc_v = 2;
    localparam int sc_n = 3;

    logic [data_w-1:0] reg_a;
    logic [data_w-1:0] reg_b;
    logic [7:0] sc;
    alu_op_e alu_op;
    logic [data_w-1:0] alu_result;
    flags_t alu_flags;
    logic cond_true;
    logic is_jump;
    logic [addr_w-1:0] offset;
    logic store_valid;
    logic [addr_w-1:0] store_addr;
    logic [data_w-1:0] store_data;

    assign exec_ready = 1'b1;

    always_comb
    begin
        case (exec_insn.opcode)
            op_sub_imm: alu_op = alu_sub;
            op_and_imm: alu_op = alu_and;
            op_or_imm:  alu_op = alu_or;
            op_xor_imm: alu_op = alu_xor;
            op_inc_a:   alu_op = alu_inc;
            op_dec_a:   alu_op = alu_dec;
            default:    alu_op = alu_add;
        endcase
    end

    alu alu_i
    (
        .op       (alu_op),
        .a        (reg_a),
        .b        (exec_insn.imm[7:0]),
        .carry_in (sc[sc_c]),
        .result   (alu_result),
        .flags    (alu_flags)
    );

    always_comb
    begin
        case (exec_insn.cond)
            cond_always:    cond_true = 1'b1;
            cond_carry:     cond_true = sc[sc_c];
            cond_non_carry: cond_true = !sc[sc_c];
            cond_zero:      cond_true = sc[sc_z];
            cond_non_zero:  cond_true = !sc[sc_z];
            cond_minus:     cond_true = sc[sc_n];
            cond_plus:      cond_true = !sc[sc_n];
            default:        cond_true = 1'b0;
        endcase
    end

    // the short form sign-extends its offset, the long form wraps at 16 bits
    assign is_jump = (exec_insn.opcode == op_jrs) || (exec_insn.opcode == op_jrl);
    assign offset = (exec_insn.opcode == op_jrs) ?
        {{8{exec_insn.imm[7]}}, exec_insn.imm[7:0]} : exec_insn.imm;

    assign redirect.valid = exec_valid && is_jump && cond_true;
    assign redirect.target = exec_insn.next_pc + offset;

    assign mem_store = '{valid: store_valid, addr: store_addr, data: store_data};

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            reg_a       <= '0;
            reg_b       <= '0;
            sc          <= 8'hC0;
            store_valid <= 1'b0;
        end
        else
        begin
            store_valid <= exec_valid &&
                ((exec_insn.opcode == op_st_a) || (exec_insn.opcode == op_st_b));
            if (exec_valid)
            begin
                case (exec_insn.opcode)
                    op_ld_a_imm:
                        reg_a <= exec_insn.imm[7:0];
                    op_ld_b_imm:
                        reg_b <= exec_insn.imm[7:0];
                    op_add_imm, op_sub_imm:
                    begin
                        reg_a    <= alu_result;
                        sc[sc_z] <= alu_flags.z;
                        sc[sc_c] <= alu_flags.c;
                        sc[sc_v] <= alu_flags.v;
                        sc[sc_n] <= alu_flags.n;
                    end
                    op_and_imm, op_or_imm, op_xor_imm:
                    begin
                        reg_a    <= alu_result;
                        sc[sc_z] <= alu_flags.z;
                        sc[sc_n] <= alu_flags.n;
                    end
                    op_inc_a, op_dec_a:
                    begin
                        reg_a    <= alu_result;
                        sc[sc_z] <= alu_flags.z;
                    end
                    default:
                    begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (exec_valid)
        begin
            store_addr <= exec_insn.imm;
            store_data <= (exec_insn.opcode == op_st_b) ? reg_b : reg_a;
        end
    end

endmodule

//--- logic/core_top.sv
`timescale 1ns/1ns

module core_top
#(
    parameter int queue_depth = 4
)
(
    input  logic                          clk,
    input  logic                          reset,
    output logic                          imem_req,
    output logic [core_pkg::addr_w-1:0]   imem_addr,
    input  logic [core_pkg::data_w-1:0]   imem_data,
    output core_pkg::store_t              mem_store
);
    import core_pkg::*;

    insn_t fetch_insn;
    logic fetch_valid;
    logic fetch_ready;
    insn_t exec_insn;
    logic exec_valid;
    logic exec_ready;
    redirect_t redirect;

    fetch_unit fetch_i
    (
        .clk         (clk),
        .reset       (reset),
        .imem_req    (imem_req),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .redirect    (redirect),
        .fetch_insn  (fetch_insn),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready)
    );

    insn_queue #(.queue_depth(queue_depth)) queue_i
    (
        .clk         (clk),
        .reset       (reset),
        .fetch_insn  (fetch_insn),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .exec_insn   (exec_insn),
        .exec_valid  (exec_valid),
        .exec_ready  (exec_ready),
        .redirect    (redirect)
    );

    execute_unit exec_i
    (
        .clk        (clk),
        .reset      (reset),
        .exec_insn  (exec_insn),
        .exec_valid (exec_valid),
        .exec_ready (exec_ready),
        .redirect   (redirect),
        .mem_store  (mem_store)
    );

endmodule

//--- verif/core_model.svh
`ifndef core_model_svh
`define core_model_svh

logic [addr_w-1:0] gen_pc;
logic [addr_w-1:0] final_pc;

// a jump takes its condition as the first operand byte
task automatic emit_insn(input logic [7:0] op, input int n_operands);
    prog_mem[gen_pc] = op;
    for (int k = 1; k <= n_operands; k++)
    begin
        if (k == 1 && (op == op_jrs || op == op_jrl))
            prog_mem[gen_pc + k] = 8'($urandom_range(6, 0));
        else
            prog_mem[gen_pc + k] = 8'($urandom);
    end
    gen_pc = gen_pc + 16'(n_operands + 1);
endtask

task automatic build_program();
    logic [addr_w-1:0] starts [0:n_insn];
    logic [addr_w-1:0] off;
    logic [addr_w-1:0] at;
    int kind;
    int tgt;
    bit prev_jump;
    for (int i = 0; i < 65536; i++)
        prog_mem[i] = 8'(i ^ (i >> 8)) ^ 8'h6C;
    gen_pc = '0;
    prev_jump = 1'b0;
    for (int i = 0; i < n_insn; i++)
    begin
        starts[i] = gen_pc;
        // the store right behind a jump sits in its shadow
        kind = prev_jump ? 14 + $urandom_range(3, 0) : $urandom_range(19, 0);
        prev_jump = (kind >= 11) && (kind <= 13);
        case (kind)
            0, 1, 2: emit_insn(op_ld_a_imm, 1);
            3:       emit_insn(op_ld_b_imm, 1);
            4:       emit_insn(op_add_imm, 1);
            5:       emit_insn(op_sub_imm, 1);
            6:       emit_insn(op_and_imm, 1);
            7:       emit_insn(op_or_imm, 1);
            8:       emit_insn(op_xor_imm, 1);
            9:       emit_insn(op_inc_a, 0);
            10:      emit_insn(op_dec_a, 0);
            11, 12:  emit_insn(op_jrs, 2);
            13:      emit_insn(op_jrl, 3);
            14, 15:  emit_insn(op_st_a, 2);
            16, 17:  emit_insn(op_st_b, 2);
            default: emit_insn(op_nop, 0);
        endcase
    end
    starts[n_insn] = gen_pc;
    final_pc = gen_pc;
    // the closing self-loop is an unconditional short jump back by its own length
    prog_mem[final_pc] = op_jrs;
    prog_mem[final_pc + 1] = {5'b0, cond_always};
    prog_mem[final_pc + 2] = 8'hFD;
    // offsets are filled in once every start address is known
    for (int i = 0; i < n_insn; i++)
    begin
        at = starts[i];
        if (prog_mem[at] == op_jrs)
        begin
            tgt = i + 1 + $urandom_range(3, 0);
            if (tgt > n_insn)
                tgt = n_insn;
            off = starts[tgt] - starts[i + 1];
            prog_mem[at + 2] = off[7:0];
        end
        else if (prog_mem[at] == op_jrl)
        begin
            tgt = $urandom_range(n_insn, i + 1);
            off = starts[tgt] - starts[i + 1];
            prog_mem[at + 2] = off[7:0];
            prog_mem[at + 3] = off[15:8];
        end
    end
endtask

// walks the program one instruction at a time and queues every store it makes
task automatic run_model();
    logic [addr_w-1:0] pc;
    logic [addr_w-1:0] nxt;
    logic [addr_w-1:0] off;
    logic [7:0] op;
    logic [7:0] opd;
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] res;
    logic z, c, n;
    logic take;
    store_t st;
    pc = '0;
    a = '0;
    b = '0;
    z = 1'b0;
    c = 1'b0;
    n = 1'b0;
    while (pc != final_pc)
    begin
        op = prog_mem[pc];
        opd = prog_mem[pc + 1];
        nxt = pc + 1;
        case (op)
            op_ld_a_imm, op_ld_b_imm:
            begin
                nxt = pc + 2;
                if (op == op_ld_a_imm)
                    a = opd;
                else
                    b = opd;
            end
            op_add_imm, op_sub_imm, op_and_imm, op_or_imm, op_xor_imm:
            begin
                nxt = pc + 2;
                case (op)
                    op_add_imm:
                    begin
                        res = a + opd;
                        c = (9'(a) + 9'(opd)) > 9'd255;
                    end
                    op_sub_imm:
                    begin
                        // C holds the borrow
                        res = a - opd;
                        c = (a < opd);
                    end
                    op_and_imm: res = a & opd;
                    op_or_imm:  res = a | opd;
                    default:    res = a ^ opd;
                endcase
                a = res;
                z = (res == 8'h00);
                n = res[7];
            end
            op_inc_a, op_dec_a:
            begin
                a = (op == op_inc_a) ? a + 8'h01 : a - 8'h01;
                z = (a == 8'h00);
            end
            op_jrs, op_jrl:
            begin
                case (opd[2:0])
                    cond_always:    take = 1'b1;
                    cond_carry:     take = c;
                    cond_non_carry: take = !c;
                    cond_zero:      take = z;
                    cond_non_zero:  take = !z;
                    cond_minus:     take = n;
                    cond_plus:      take = !n;
                    default:        take = 1'b0;
                endcase
                if (op == op_jrs)
                begin
                    nxt = pc + 3;
                    off = {{8{prog_mem[pc + 2][7]}}, prog_mem[pc + 2]};
                end
                else
                begin
                    nxt = pc + 4;
                    off = {prog_mem[pc + 3], prog_mem[pc + 2]};
                end
                if (take)
                    nxt = nxt + off;
            end
            op_st_a, op_st_b:
            begin
                nxt = pc + 3;
                st.valid = 1'b1;
                st.addr = {prog_mem[pc + 2], prog_mem[pc + 1]};
                st.data = (op == op_st_b) ? b : a;
                exp_q.push_back(st);
            end
            default:
            begin
            end
        endcase
        pc = nxt;
    end
endtask

`endif

//--- verif/tb_core.sv
`timescale 1ns/1ns

module tb_core;
    import core_pkg::*;

    localparam int n_insn = 40;
    // worst case of four bytes and four cycles per instruction, plus slack
    localparam int timeout_cycles = n_insn * 4 * 4 + 100;

    logic clk;
    logic reset;
    logic imem_req;
    logic [addr_w-1:0] imem_addr;
    logic [data_w-1:0] imem_data;
    store_t mem_store;

    logic [7:0] prog_mem [0:65535];
    store_t exp_q [$];
    logic req_seen = 1'b0;
    logic [addr_w-1:0] req_addr;

    `include "core_model.svh"

    core_top dut_i
    (
        .clk       (clk),
        .reset     (reset),
        .imem_req  (imem_req),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .mem_store (mem_store)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp)
            fail_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
    endtask

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // program memory answers one cycle after the request
    always @(posedge clk)
    begin
        req_seen <= imem_req;
        req_addr <= imem_addr;
    end

    always @(negedge clk)
    begin
        if (req_seen)
            imem_data <= prog_mem[req_addr];
    end

    // stores are compared in order against the model's list
    always @(negedge clk)
    begin
        if (!reset && mem_store.valid)
        begin
            if (exp_q.size() == 0)
                fail_run($sformatf("unexpected store to address %h after the last expected store",
                                   mem_store.addr));
            else
            begin
                check_value("mem_store.addr", mem_store.addr, exp_q[0].addr);
                check_value("mem_store.data", 16'(mem_store.data), 16'(exp_q[0].data));
                void'(exp_q.pop_front());
            end
        end
    end

    initial
    begin
        repeat (timeout_cycles) @(posedge clk);
        fail_run($sformatf("timeout after %0d cycles with %0d stores still missing",
                           timeout_cycles, exp_q.size()));
    end

    initial
    begin
        reset = 1'b1;
        imem_data = '0;
        void'($urandom(82));
        build_program();
        run_model();
        $display("program of %0d instructions ends at %h, %0d stores expected",
                 n_insn, final_pc, exp_q.size());
        repeat (4) @(negedge clk);
        reset = 1'b0;
        while (exp_q.size() != 0)
            @(posedge clk);
        // the store checker still watches these idle cycles
        repeat (20) @(posedge clk);
        $display("All checks passed");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+verif
logic/core_pkg.sv
logic/alu.sv
logic/fetch_unit.sv
logic/insn_queue.sv
logic/execute_unit.sv
logic/core_top.sv
verif/tb_core.sv

//--- Bender.yml
package:
  name: core88

sources:
  - logic/core_pkg.sv
  - logic/alu.sv
  - logic/fetch_unit.sv
  - logic/insn_queue.sv
  - logic/execute_unit.sv
  - logic/core_top.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/tb_core.sv
